/* compile.f */
hw/linkPkg.sv
hw/uartRx.sv
hw/uartTx.sv
hw/widthShifter.sv
hw/blockStore.sv
hw/cmdEngine.sv
hw/memLinkTop.sv
dv/memLinkTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide by the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module memLinkTb -f compile.f -o memLinkSim &&
	./obj_dir/memLinkSim > sim.log 2>&1
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* dv/memLinkTb.sv */
`timescale 1ns/1ps

module memLinkTb;

	localparam int ClkPerBit = linkPkg::DefClkPerBit;
	localparam int FillCount = linkPkg::DefFillCount;
	localparam int StoreDepth = linkPkg::DefStoreDepth;
	localparam int AddrBits = $clog2(StoreDepth);
	localparam int NumWrites = 4;
	// Writes, reads plus one wrap read, fill plus its reads, unknown plus read, back to back
	localparam int NumCmds = NumWrites + (NumWrites + 1) + (FillCount + 1) + 2 + 4;
	// Seven bytes in and four out, ten bits each, with half again as margin
	localparam int CmdCycles = 11 * 10 * ClkPerBit;
	localparam int TimeoutCycles = NumCmds * CmdCycles * 3 / 2 + 1000;

	logic sys_clk_p;
	logic rstN;
	logic serIn;
	logic serOut;

	// Host model state
	logic [15:0] lfsrState;
	logic cmdStarted;
	int cycleCnt;

	// Reference store and expected responses
	linkPkg::wordT refMem [StoreDepth];
	linkPkg::wordT expQ [$];

	// Receiver outputs change on falling edges only
	logic respDone;
	logic expValid;
	logic frameErr;
	linkPkg::wordT respWord;
	linkPkg::wordT expWord;

	memLinkTop #(
		.ClkPerBit(ClkPerBit),
		.FillCount(FillCount),
		.StoreDepth(StoreDepth)
	) UUT (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.serIn(serIn),
		.serOut(serOut)
	);

	initial begin
		sys_clk_p = 1'b0;
		forever #5 sys_clk_p = ~sys_clk_p;
	end

	// ------------------------------------------------------------------------
	// Random numbers and host model
	// ------------------------------------------------------------------------

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Start bit, eight data bits LSB first, stop bit
	task automatic sendByte(input linkPkg::byteT b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge sys_clk_p);
			serIn = frame[i];
			cmdStarted = 1'b1;
			repeat (ClkPerBit - 1) @(negedge sys_clk_p);
		end
	endtask

	// Update the reference store, queue the answer, then send the packet MSB first
	task automatic sendCmd(input logic [7:0] op, input linkPkg::addrT addr,
		input linkPkg::wordT data);
		logic [55:0] pkt;
		logic [AddrBits-1:0] idx;
		linkPkg::wordT expResp;
		pkt = {op, addr, data};
		idx = AddrBits'(int'(addr) % StoreDepth);
		case (op)
			linkPkg::OpWrite: begin
				refMem[idx] = data;
				expResp = data;
			end
			linkPkg::OpRead: expResp = refMem[idx];
			linkPkg::OpFill: begin
				for (int k = 0; k < FillCount; k++) begin
					idx = AddrBits'((int'(addr) + k) % StoreDepth);
					refMem[idx] = data + linkPkg::wordT'(k);
				end
				expResp = linkPkg::wordT'(FillCount);
			end
			// Store untouched
			default: expResp = '1;
		endcase
		expQ.push_back(expResp);
		for (int i = 6; i >= 0; i--)
			sendByte(pkt[i*8 +: 8]);
	endtask

	task automatic drainResponses();
		while (expQ.size() != 0)
			@(negedge sys_clk_p);
	endtask

	// ------------------------------------------------------------------------
	// Serial receiver that rebuilds response words from serOut
	// ------------------------------------------------------------------------

	initial begin : rxModel
		linkPkg::byteT rxByte;
		linkPkg::wordT word;
		wait (rstN === 1'b1);
		forever begin
			word = '0;
			for (int b = 0; b < 4; b++) begin
				@(negedge sys_clk_p);
				while (serOut !== 1'b0)
					@(negedge sys_clk_p);
				// Middle of the start bit and then one bit period per sample
				repeat (ClkPerBit / 2) @(negedge sys_clk_p);
				for (int i = 0; i < 8; i++) begin
					repeat (ClkPerBit) @(negedge sys_clk_p);
					rxByte[i] = serOut;
				end
				repeat (ClkPerBit) @(negedge sys_clk_p);
				if (serOut !== 1'b1)
					frameErr = 1'b1;
				word = {word[23:0], rxByte};
			end
			expValid = (expQ.size() != 0);
			if (expValid)
				expWord = expQ.pop_front();
			respWord = word;
			respDone = 1'b1;
			@(negedge sys_clk_p);
			respDone = 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------

	respMatch: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		respDone && expValid |-> respWord == expWord)
	else begin
		$display("Fail respWord expected 0x%08h actual 0x%08h", expWord, respWord);
		$display("tests failed");
		$fatal(1);
	end

	respExpected: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		respDone |-> expValid)
	else begin
		$display("A response word came back with no command outstanding");
		$display("tests failed");
		$fatal(1);
	end

	// Line quiet until the host talks
	idleBeforeCmd: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		!cmdStarted |-> serOut)
	else begin
		$display("serOut left its idle level before the first command");
		$display("tests failed");
		$fatal(1);
	end

	stopBitHigh: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		!frameErr)
	else begin
		$display("A response byte on serOut had a low stop bit");
		$display("tests failed");
		$fatal(1);
	end

	always @(posedge sys_clk_p) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt == TimeoutCycles) begin
			$display("Run timed out after %0d cycles, %0d responses missing",
				cycleCnt, expQ.size());
			$display("tests failed");
			$fatal(1);
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		linkPkg::addrT wrAddr [NumWrites];
		linkPkg::addrT fillBase;
		linkPkg::addrT addrA;
		linkPkg::addrT addrB;
		serIn = 1'b1;
		rstN = 1'b0;
		lfsrState = 16'd36763;
		cmdStarted = 1'b0;
		respDone = 1'b0;
		expValid = 1'b0;
		frameErr = 1'b0;
		respWord = '0;
		expWord = '0;
		repeat (8) @(negedge sys_clk_p);
		rstN = 1'b1;
		// Quiet stretch so the idle check has something to watch
		repeat (40) @(negedge sys_clk_p);

		// Random writes that each come back as an echo
		for (int i = 0; i < NumWrites; i++) begin
			wrAddr[i] = linkPkg::addrT'(randBits(16));
			sendCmd(linkPkg::OpWrite, wrAddr[i], randBits(32));
			drainResponses();
		end

		// Read back each word and once more through an address above the store size
		for (int i = 0; i < NumWrites; i++) begin
			sendCmd(linkPkg::OpRead, wrAddr[i], '0);
			drainResponses();
		end
		sendCmd(linkPkg::OpRead, wrAddr[0] + linkPkg::addrT'(StoreDepth), '0);
		drainResponses();

		// Fill placed near the top of the store so it wraps round to zero
		fillBase = linkPkg::addrT'(randBits(16));
		fillBase = (fillBase & ~linkPkg::addrT'(StoreDepth - 1))
			| linkPkg::addrT'(StoreDepth - FillCount / 2);
		sendCmd(linkPkg::OpFill, fillBase, randBits(32));
		drainResponses();
		for (int k = 0; k < FillCount; k++) begin
			sendCmd(linkPkg::OpRead, fillBase + linkPkg::addrT'(k), '0);
			drainResponses();
		end

		// Unknown opcode and a read proving the word survived
		sendCmd(8'h33, wrAddr[1], randBits(32));
		drainResponses();
		sendCmd(linkPkg::OpRead, wrAddr[1], '0);
		drainResponses();

		// Back to back frames while responses are still going out
		addrA = linkPkg::addrT'(randBits(16));
		addrB = linkPkg::addrT'(randBits(16));
		sendCmd(linkPkg::OpWrite, addrA, randBits(32));
		sendCmd(linkPkg::OpRead, addrA, '0);
		sendCmd(linkPkg::OpWrite, addrB, randBits(32));
		sendCmd(linkPkg::OpRead, addrB, '0);
		drainResponses();

		// Let the last comparison land
		repeat (2) @(negedge sys_clk_p);
		$display("all tests passed");
		$finish;
	end

endmodule

/* hw/memLinkTop.sv */
`timescale 1ns/1ps

module memLinkTop #(
	parameter int ClkPerBit = linkPkg::DefClkPerBit,
	parameter int FillCount = linkPkg::DefFillCount,
	parameter int StoreDepth = linkPkg::DefStoreDepth
) (
	input logic sys_clk_p,
	input logic rstN,
	input logic serIn,
	output logic serOut
);

	// Receiver to request shifter
	linkPkg::byteT rxData;
	logic rxValid;
	logic rxReady;

	// Request shifter to engine
	logic [linkPkg::CmdWidth-1:0] cmdData;
	logic cmdValid;
	logic cmdReady;

	// Engine to response shifter
	linkPkg::wordT respData;
	logic respValid;
	logic respReady;

	// Response shifter to transmitter
	linkPkg::byteT txData;
	logic txValid;
	logic txReady;

	// Engine to store
	logic memEn;
	logic memWe;
	linkPkg::addrT memAddr;
	linkPkg::wordT memWData;
	linkPkg::wordT memRData;

	// ------------------------------------------------------------------------
	// Request path
	// ------------------------------------------------------------------------

	uartRx #(.ClkPerBit(ClkPerBit)) rxUnit (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.serIn(serIn),
		.rxData(rxData),
		.rxValid(rxValid)
	);

	// Seven bytes, MSB first, into one packet
	widthShifter #(
		.IWidth(8),
		.OWidth(linkPkg::CmdWidth),
		.Reverse(1'b1)
	) reqShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(rxData),
		.inValid(rxValid),
		.inReady(rxReady),
		.outData(cmdData),
		.outValid(cmdValid),
		.outReady(cmdReady)
	);

	// ------------------------------------------------------------------------
	// Engine and store
	// ------------------------------------------------------------------------

	cmdEngine #(.FillCount(FillCount)) engine (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.cmdData(cmdData),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.respData(respData),
		.respValid(respValid),
		.respReady(respReady),
		.memEn(memEn),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRData(memRData)
	);

	blockStore #(.StoreDepth(StoreDepth)) store (
		.sys_clk_p(sys_clk_p),
		.memEn(memEn),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRData(memRData)
	);

	// ------------------------------------------------------------------------
	// Response path
	// ------------------------------------------------------------------------

	// Response word back out as four bytes, MSB first
	widthShifter #(
		.IWidth(linkPkg::RespWidth),
		.OWidth(8),
		.Reverse(1'b1)
	) respShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(respData),
		.inValid(respValid),
		.inReady(respReady),
		.outData(txData),
		.outValid(txValid),
		.outReady(txReady)
	);

	uartTx #(.ClkPerBit(ClkPerBit)) txUnit (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.txData(txData),
		.txValid(txValid),
		.txReady(txReady),
		.serOut(serOut)
	);

	// Receiver has no stall, a refused byte means the request buffer overflowed
	rxNoOverflow: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		rxValid |-> rxReady);

endmodule

/* hw/cmdEngine.sv */
`timescale 1ns/1ps

module cmdEngine #(
	parameter int FillCount = linkPkg::DefFillCount
) (
	input logic sys_clk_p,
	input logic rstN,
	input logic [linkPkg::CmdWidth-1:0] cmdData,
	input logic cmdValid,
	output logic cmdReady,
	output linkPkg::wordT respData,
	output logic respValid,
	input logic respReady,
	output logic memEn,
	output logic memWe,
	output linkPkg::addrT memAddr,
	output linkPkg::wordT memWData,
	input linkPkg::wordT memRData
);

	// Index must reach FillCount itself to mark the end of a fill
	localparam int IdxWidth = $clog2(FillCount + 1);
	localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(FillCount);

	linkPkg::engineStateT state;
	linkPkg::opcodeT cmdOp;
	linkPkg::opcodeT opReg;
	linkPkg::addrT cmdAddr;
	linkPkg::addrT baseAddr;
	linkPkg::wordT cmdWord;
	linkPkg::wordT baseData;
	logic [IdxWidth-1:0] fillIdx;
	logic accept;
	logic fillDone;

	// ------------------------------------------------------------------------
	// Packet fields
	// ------------------------------------------------------------------------

	// Top byte opcode, then address, then data
	assign cmdOp = linkPkg::opcodeT'(cmdData[linkPkg::CmdWidth-1 -: 8]);
	assign cmdAddr = cmdData[linkPkg::CmdWidth-9 -: 16];
	assign cmdWord = cmdData[linkPkg::RespWidth-1:0];

	// Only idle takes a packet
	assign cmdReady = (state == linkPkg::EngIdle);
	assign accept = cmdValid && cmdReady;
	assign fillDone = (state == linkPkg::EngFill) && (fillIdx == LastIdx);

	// ------------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------------

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			state <= linkPkg::EngIdle;
			respValid <= 1'b0;
			memEn <= 1'b0;
			memWe <= 1'b0;
			fillIdx <= '0;
		end else begin
			case (state)
				linkPkg::EngIdle: begin
					if (accept) begin
						case (cmdOp)
							linkPkg::OpWrite: begin
								memEn <= 1'b1;
								memWe <= 1'b1;
								state <= linkPkg::EngReadWait;
							end
							linkPkg::OpRead: begin
								memEn <= 1'b1;
								state <= linkPkg::EngReadWait;
							end
							linkPkg::OpFill: begin
								fillIdx <= '0;
								state <= linkPkg::EngFill;
							end
							// Unknown opcode answers right away
							default: begin
								respValid <= 1'b1;
								state <= linkPkg::EngRespond;
							end
						endcase
					end
				end
				linkPkg::EngReadWait: begin
					memEn <= 1'b0;
					memWe <= 1'b0;
					// Write is done now, a read needs its data cycle first
					if (opReg == linkPkg::OpWrite || !memEn) begin
						respValid <= 1'b1;
						state <= linkPkg::EngRespond;
					end
				end
				linkPkg::EngFill: begin
					if (fillDone) begin
						memEn <= 1'b0;
						memWe <= 1'b0;
						respValid <= 1'b1;
						state <= linkPkg::EngRespond;
					end else begin
						memEn <= 1'b1;
						memWe <= 1'b1;
						fillIdx <= fillIdx + 1'b1;
					end
				end
				linkPkg::EngRespond: begin
					// Response shifter back-pressure holds us here
					if (respReady) begin
						respValid <= 1'b0;
						state <= linkPkg::EngIdle;
					end
				end
				default: state <= linkPkg::EngIdle;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Datapath
	// ------------------------------------------------------------------------

	always_ff @(posedge sys_clk_p) begin
		if (accept) begin
			opReg <= cmdOp;
			baseAddr <= cmdAddr;
			baseData <= cmdWord;
			memAddr <= cmdAddr;
			memWData <= cmdWord;
			// Default answer, overwritten by known opcodes
			respData <= '1;
		end
		// Fill word k goes to base plus k, address wraps in the store
		if (state == linkPkg::EngFill && !fillDone) begin
			memAddr <= baseAddr + linkPkg::addrT'(fillIdx);
			memWData <= baseData + linkPkg::wordT'(fillIdx);
		end
		// Last capture before respond holds the fresh read data
		if (state == linkPkg::EngReadWait)
			respData <= (opReg == linkPkg::OpWrite) ? baseData : memRData;
		if (fillDone)
			respData <= linkPkg::wordT'(FillCount);
	end

	memWeNeedsEn: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		memWe |-> memEn);

	// Taking a packet while a store access or response is pending would lose it
	readyOnlyIdle: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		cmdReady |-> (state == linkPkg::EngIdle) && !respValid && !memEn);

endmodule

/* hw/blockStore.sv */
`timescale 1ns/1ps

module blockStore #(
	parameter int StoreDepth = linkPkg::DefStoreDepth
) (
	input logic sys_clk_p,
	input logic memEn,
	input logic memWe,
	input linkPkg::addrT memAddr,
	input linkPkg::wordT memWData,
	output linkPkg::wordT memRData
);

	localparam int AddrBits = $clog2(StoreDepth);

	linkPkg::wordT storeArr [StoreDepth];
	logic [AddrBits-1:0] wordAddr;

	// Upper address bits dropped, so addresses wrap onto the store
	assign wordAddr = memAddr[AddrBits-1:0];

	// ------------------------------------------------------------------------
	// Single port, one cycle read latency
	// ------------------------------------------------------------------------

	always_ff @(posedge sys_clk_p) begin
		if (memEn) begin
			if (memWe)
				storeArr[wordAddr] <= memWData;
			else
				// Read data holds until the next enabled read
				memRData <= storeArr[wordAddr];
		end
	end

endmodule

/* hw/widthShifter.sv */
`timescale 1ns/1ps

module widthShifter #(
	parameter int IWidth = 8,
	parameter int OWidth = linkPkg::CmdWidth,
	// Set means most significant piece travels first
	parameter bit Reverse = 1'b1
) (
	input logic sys_clk_p,
	input logic rstN,
	input logic [IWidth-1:0] inData,
	input logic inValid,
	output logic inReady,
	output logic [OWidth-1:0] outData,
	output logic outValid,
	input logic outReady
);

	generate
		if (IWidth < OWidth) begin : gGather
			// ----------------------------------------------------------------
			// Narrow to wide, gather pieces then park the word
			// ----------------------------------------------------------------
			localparam int Ratio = OWidth / IWidth;
			localparam int CntWidth = $clog2(Ratio);
			localparam logic [CntWidth-1:0] LastCnt = CntWidth'(Ratio - 1);

			logic [CntWidth-1:0] pieceCnt;
			logic [OWidth-1:0] accReg;
			logic [OWidth-1:0] accNext;
			logic [OWidth-1:0] outReg;
			logic lastPiece;
			logic inFire;
			logic outFire;

			assign lastPiece = (pieceCnt == LastCnt);
			assign inFire = inValid && inReady;
			assign outFire = outValid && outReady;
			// Next word may gather freely, only its last piece waits for room
			assign inReady = !(lastPiece && outValid && !outReady);
			assign outData = outReg;

			// First piece ends up on top when reversed
			assign accNext = Reverse ? {accReg[OWidth-IWidth-1:0], inData}
				: {inData, accReg[OWidth-1:IWidth]};

			always_ff @(posedge sys_clk_p or negedge rstN) begin
				if (!rstN) begin
					pieceCnt <= '0;
					outValid <= 1'b0;
				end else begin
					if (inFire)
						pieceCnt <= lastPiece ? '0 : pieceCnt + 1'b1;
					if (outFire)
						outValid <= 1'b0;
					// Completed word wins over a drain on the same edge
					if (inFire && lastPiece)
						outValid <= 1'b1;
				end
			end

			always_ff @(posedge sys_clk_p) begin
				if (inFire)
					accReg <= accNext;
				if (inFire && lastPiece)
					outReg <= accNext;
			end
		end else begin : gSplit
			// ----------------------------------------------------------------
			// Wide to narrow, load the word and shift out pieces
			// ----------------------------------------------------------------
			localparam int Ratio = IWidth / OWidth;
			localparam int CntWidth = $clog2(Ratio);
			localparam logic [CntWidth-1:0] LastCnt = CntWidth'(Ratio - 1);

			logic [IWidth-1:0] shiftReg;
			logic [CntWidth-1:0] pieceCnt;
			logic lastPiece;
			logic inFire;
			logic outFire;

			assign lastPiece = (pieceCnt == LastCnt);
			assign inFire = inValid && inReady;
			assign outFire = outValid && outReady;
			// Holds the producer until every piece is gone
			assign inReady = !outValid;
			assign outData = Reverse ? shiftReg[IWidth-1 -: OWidth] : shiftReg[OWidth-1:0];

			always_ff @(posedge sys_clk_p or negedge rstN) begin
				if (!rstN) begin
					pieceCnt <= '0;
					outValid <= 1'b0;
				end else if (inFire) begin
					pieceCnt <= '0;
					outValid <= 1'b1;
				end else if (outFire) begin
					pieceCnt <= pieceCnt + 1'b1;
					if (lastPiece)
						outValid <= 1'b0;
				end
			end

			always_ff @(posedge sys_clk_p) begin
				if (inFire)
					shiftReg <= inData;
				else if (outFire)
					shiftReg <= Reverse ? (shiftReg << OWidth) : (shiftReg >> OWidth);
			end
		end
	endgenerate

	// Offered data must not move under a stalled consumer
	outDataStable: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData));

endmodule

/* hw/uartTx.sv */
`timescale 1ns/1ps

module uartTx #(
	parameter int ClkPerBit = linkPkg::DefClkPerBit
) (
	input logic sys_clk_p,
	input logic rstN,
	input linkPkg::byteT txData,
	input logic txValid,
	output logic txReady,
	output logic serOut
);

	localparam int CntWidth = $clog2(ClkPerBit);
	localparam logic [CntWidth-1:0] LastCnt = CntWidth'(ClkPerBit - 1);

	linkPkg::txStateT state;
	// Stop bit, eight data bits, start bit in the LSB
	logic [9:0] frameReg;
	logic [CntWidth-1:0] clkCnt;
	logic [3:0] bitIdx;

	// Accept a new byte only between frames
	assign txReady = (state == linkPkg::TxIdle);
	assign serOut = frameReg[0];

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			state <= linkPkg::TxIdle;
			// All ones keeps the line at its idle level
			frameReg <= '1;
			clkCnt <= '0;
			bitIdx <= '0;
		end else begin
			case (state)
				linkPkg::TxIdle: begin
					if (txValid) begin
						frameReg <= {1'b1, txData, 1'b0};
						clkCnt <= '0;
						bitIdx <= '0;
						state <= linkPkg::TxShift;
					end
				end
				linkPkg::TxShift: begin
					if (clkCnt == LastCnt) begin
						clkCnt <= '0;
						// Ones fill in behind, line is high once the frame is out
						frameReg <= {1'b1, frameReg[9:1]};
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 4'd9)
							state <= linkPkg::TxIdle;
					end else begin
						clkCnt <= clkCnt + 1'b1;
					end
				end
				default: state <= linkPkg::TxIdle;
			endcase
		end
	end

	// Line must rest high between frames
	serOutIdleHigh: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		(state == linkPkg::TxIdle) |-> serOut);

endmodule

/* hw/uartRx.sv */
`timescale 1ns/1ps

module uartRx #(
	parameter int ClkPerBit = linkPkg::DefClkPerBit
) (
	input logic sys_clk_p,
	input logic rstN,
	input logic serIn,
	output linkPkg::byteT rxData,
	output logic rxValid
);

	localparam int CntWidth = $clog2(ClkPerBit);
	// Full bit period, and half of it to land in the middle of the start bit
	localparam logic [CntWidth-1:0] LastCnt = CntWidth'(ClkPerBit - 1);
	localparam logic [CntWidth-1:0] HalfCnt = CntWidth'(ClkPerBit / 2 - 1);

	linkPkg::rxStateT state;
	logic [1:0] syncReg;
	logic serLine;
	logic [CntWidth-1:0] clkCnt;
	logic [2:0] bitIdx;
	linkPkg::byteT shiftReg;
	logic sampleNow;

	// Synchronized copy of the line
	assign serLine = syncReg[1];
	// One full bit after the last sample point
	assign sampleNow = (clkCnt == LastCnt);
	// Shift register is stable from the last data bit until the next frame
	assign rxData = shiftReg;

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			// Line idles high
			syncReg <= 2'b11;
			state <= linkPkg::RxIdle;
			clkCnt <= '0;
			bitIdx <= '0;
			rxValid <= 1'b0;
		end else begin
			syncReg <= {syncReg[0], serIn};
			rxValid <= 1'b0;
			clkCnt <= clkCnt + 1'b1;
			case (state)
				linkPkg::RxIdle: begin
					clkCnt <= '0;
					// Falling edge marks a start bit
					if (!serLine)
						state <= linkPkg::RxStart;
				end
				linkPkg::RxStart: begin
					if (clkCnt == HalfCnt) begin
						clkCnt <= '0;
						bitIdx <= '0;
						// Glitch shorter than half a bit goes back to idle
						state <= serLine ? linkPkg::RxIdle : linkPkg::RxData;
					end
				end
				linkPkg::RxData: begin
					if (sampleNow) begin
						clkCnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= linkPkg::RxStop;
					end
				end
				linkPkg::RxStop: begin
					if (sampleNow) begin
						clkCnt <= '0;
						// Low stop bit is a framing error, byte dropped
						rxValid <= serLine;
						state <= linkPkg::RxIdle;
					end
				end
				default: state <= linkPkg::RxIdle;
			endcase
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge sys_clk_p) begin
		if (state == linkPkg::RxData && sampleNow)
			shiftReg <= {serLine, shiftReg[7:1]};
	end

	// One byte per frame, never a stretched strobe
	rxValidPulse: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		rxValid |=> !rxValid);

endmodule

/* hw/linkPkg.sv */
package linkPkg;

	// ------------------------------------------------------------------------
	// Widths on the serial link
	// ------------------------------------------------------------------------

	// One UART character
	typedef logic [7:0] byteT;

	// Word address as carried in a command packet
	typedef logic [15:0] addrT;

	// Data word and response word
	typedef logic [31:0] wordT;

	// Packet layout is opcode, then address, then data, MSB first
	localparam int CmdWidth = 56;
	localparam int RespWidth = 32;

	// Opcodes understood by the command engine, all others answer all ones
	typedef enum logic [7:0] {
		OpWrite = 8'd0,
		OpRead = 8'd2,
		OpFill = 8'd4
	} opcodeT;

	// ------------------------------------------------------------------------
	// State machines
	// ------------------------------------------------------------------------

	typedef enum logic [1:0] {EngIdle, EngReadWait, EngFill, EngRespond} engineStateT;

	typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rxStateT;

	typedef enum logic {TxIdle, TxShift} txStateT;

	// ------------------------------------------------------------------------
	// Defaults for the top-level parameters
	// ------------------------------------------------------------------------

	localparam int DefClkPerBit = 16;
	localparam int DefFillCount = 16;
	localparam int DefStoreDepth = 256;

endpackage
